/* datapath.f */
+incdir+include
+incdir+testbench
hw/datapathPkg.sv
hw/busIf.sv
hw/busDecode.sv
hw/aluExecute.sv
hw/registerFile.sv
hw/datapath.sv
testbench/clockGen.sv
testbench/datapath_chk.sv
testbench/datapathTb.sv

/* Makefile */
# Verilator build and run for the datapath testbench

VERILATOR ?= verilator
TOP       ?= datapathTb
FILELIST  ?= datapath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
SIMFLAGS  ?= +verilator+error+limit+100
PASS_TEXT ?= all tests passed

SOURCES := $(wildcard hw/*.sv testbench/*.sv testbench/*.svh include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/datapathTbTasks.svh */
`ifndef DATAPATH_TB_TASKS_SVH
`define DATAPATH_TB_TASKS_SVH

    // 32-bit xorshift
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Three-register format with the opcode left at zero
    function automatic logic [31:0] makeInstr(input logic [3:0] ra, input logic [3:0] rb,
                                              input logic [3:0] rc);
        return {5'd0, ra, rb, rc, 15'd0};
    endfunction

    task automatic clearStrobes();
        {rOut, hiOut, loOut, pcOut, zHighOut, zLowOut, mdrOut, inPortOut, cOut, baOut} = '0;
        {rIn, hiIn, loIn, pcIn, irIn, yIn, zIn, marIn, mdrIn} = '0;
        {gra, grb, grc, read} = '0;
    endtask

    // One cycle, strobes dropped on the next falling edge
    task automatic tick();
        @(negedge Clock);
        clearStrobes();
    endtask

    task automatic loadIr(input logic [31:0] word);
        inPort = word;
        inPortOut = 1'b1;
        irIn = 1'b1;
        tick();
    endtask

    // IR gets ra = index, then the word goes through MDR into the register
    task automatic loadRegister(input logic [3:0] index, input logic [31:0] value);
        loadIr(makeInstr(index, 4'd0, 4'd0));
        mDataIn = value;
        read = 1'b1;
        mdrIn = 1'b1;
        tick();
        mdrOut = 1'b1;
        rIn = 1'b1;
        gra = 1'b1;
        tick();
    endtask

    task automatic aluSequence(input datapathPkg::aluOpT op, input logic [31:0] a,
                               input logic [31:0] b);
        logic [63:0] expected;
        loadRegister(4'd1, a);
        loadRegister(4'd2, b);
        loadIr(makeInstr(4'd1, 4'd2, 4'd0));
        rOut = 1'b1;
        gra = 1'b1;
        yIn = 1'b1;
        tick();
        rOut = 1'b1;
        grb = 1'b1;
        zIn = 1'b1;
        aluOp = op;
        tick();
        expected = aluRef(op, a, b);
        zLowOut = 1'b1;
        observe($sformatf("%s low", op.name()), expected[31:0], 1'b0);
        zHighOut = 1'b1;
        observe($sformatf("%s high", op.name()), expected[63:32], 1'b0);
    endtask

`endif

/* testbench/datapathTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module datapathTb;

    localparam int waitLimit = 20;   // Cycles allowed for any wait

    logic Clock;
    logic rstN;
    logic rOut, hiOut, loOut, pcOut, zHighOut, zLowOut, mdrOut, inPortOut, cOut, baOut;
    logic rIn, hiIn, loIn, pcIn, irIn, yIn, zIn, marIn, mdrIn;
    logic gra, grb, grc, read;
    datapathPkg::aluOpT     aluOp;
    logic [`DATA_WIDTH-1:0] mDataIn;
    logic [`DATA_WIDTH-1:0] inPort;
    logic [`DATA_WIDTH-1:0] busData;
    logic [`DATA_WIDTH-1:0] marAddr;
    logic                   busConflict;

    logic [31:0] rngState = 32'h396b;
    int          errorCount = 0;
    int          checkCount = 0;
    logic        obsActive = 1'b0;   // Marks an observe cycle for the comparing process
    string       obsName;
    logic [31:0] obsExpected;
    logic        obsConflict;

    clockGen clk0 (.Clock, .rstN);

    datapath dut0 (.*);

    `include "datapathTbTasks.svh"

    // Expected {Z high, Z low} for Y = a and bus = b
    function automatic logic [63:0] aluRef(input datapathPkg::aluOpT op, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] low;
        int          sa;
        int          sb;
        sh = b[4:0];
        sa = a;
        sb = b;
        low = 32'd0;
        case (op)
            datapathPkg::aluAdd:  low = a + b;
            datapathPkg::aluSub:  low = a - b;
            datapathPkg::aluAnd:  low = a & b;
            datapathPkg::aluOr:   low = a | b;
            datapathPkg::aluShr:  low = a >> sh;
            datapathPkg::aluShra: low = (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0);
            datapathPkg::aluShl:  low = a << sh;
            datapathPkg::aluRor:  low = (sh == 5'd0) ? a : (a >> sh) | (a << (6'd32 - {1'b0, sh}));
            datapathPkg::aluRol:  low = (sh == 5'd0) ? a : (a << sh) | (a >> (6'd32 - {1'b0, sh}));
            datapathPkg::aluNeg:  low = 32'd0 - b;
            datapathPkg::aluNot:  low = ~b;
            datapathPkg::aluInc:  low = b + 32'd1;
            datapathPkg::aluMul:  return longint'(sa) * longint'(sb);
            datapathPkg::aluDiv: begin
                if (b == 32'd0)
                    return {a, 32'hffffffff};   // Remainder Y and quotient all ones
                return {32'(sa % sb), 32'(sa / sb)};
            end
            default: low = 32'd0;
        endcase
        return {32'd0, low};
    endfunction

    // Bus sampled on the rising edge when the inputs are stable
    always @(posedge Clock) begin
        if (obsActive) begin
            if (busData !== obsExpected) begin
                errorCount++;
                $display("FAILED %s: expected %h, actual %h", obsName, obsExpected, busData);
            end
            if (busConflict !== obsConflict) begin
                errorCount++;
                $display("FAILED %s busConflict: expected %b, actual %b",
                         obsName, obsConflict, busConflict);
            end
            checkCount++;
        end
    end

    // Holds the out strobes already driven for one checked cycle
    task automatic observe(input string name, input logic [31:0] expected,
                           input logic conflict);
        int waited;
        int startCount;
        obsName = name;
        obsExpected = expected;
        obsConflict = conflict;
        obsActive = 1'b1;
        startCount = checkCount;
        waited = 0;
        while (checkCount == startCount && waited < waitLimit) begin
            @(negedge Clock);
            waited++;
        end
        obsActive = 1'b0;
        if (checkCount == startCount) begin
            errorCount++;
            $display("Timed out waiting for the bus check of %s", name);
        end
        clearStrobes();
    endtask

    initial begin
        int          waited;
        logic [31:0] value;
        logic [31:0] a;
        logic [31:0] b;
        logic [18:0] imm;
        logic [31:0] immExpected;
        logic [63:0] product;
        logic [31:0] regValues [`REG_COUNT];
        clearStrobes();
        aluOp = datapathPkg::aluAdd;
        mDataIn = 32'd0;
        inPort = 32'd0;
        pcOut = 1'b1;   // PC read across the end of reset
        waited = 0;
        while (rstN !== 1'b1 && waited < waitLimit) begin
            @(negedge Clock);
            waited++;
        end
        if (rstN !== 1'b1) begin
            errorCount++;
            $display("Reset was never released");
        end else begin
            observe("pc after reset", 32'd0, 1'b0);

            // Every register through MDR including R0
            for (int r = 0; r < `REG_COUNT; r++) begin
                regValues[r] = nextRandom();
                loadRegister(4'(r), regValues[r]);
            end
            // Read back after all loads to catch aliased registers
            for (int r = 0; r < `REG_COUNT; r++) begin
                loadIr(makeInstr(4'(r), 4'd0, 4'd0));
                rOut = 1'b1;
                gra = 1'b1;
                observe($sformatf("r%0d read", r), regValues[r], 1'b0);
            end
            loadIr(makeInstr(4'd0, 4'd0, 4'd0));
            baOut = 1'b1;
            gra = 1'b1;
            observe("r0 as base", 32'd0, 1'b0);

            for (int pass = 0; pass < 2; pass++) begin
                for (int i = 0; i <= 13; i++) begin
                    a = nextRandom();
                    b = nextRandom();
                    aluSequence(datapathPkg::aluOpT'(4'(i)), a, b);
                end
            end
            aluSequence(datapathPkg::aluDiv, nextRandom(), 32'd0);

            for (int k = 0; k < 4; k++) begin
                value = nextRandom();
                case (k)
                    0:       imm = 19'h01234;
                    1:       imm = 19'h7fff0;
                    2:       imm = 19'h40000;
                    default: imm = value[18:0];
                endcase
                loadIr({13'd0, imm});
                cOut = 1'b1;
                immExpected = 32'(imm);
                if (imm[18])
                    immExpected = immExpected - 32'h80000;   // Negative field is imm minus 2^19
                observe("immediate", immExpected, 1'b0);
            end

            // PC still at its reset value of zero
            for (int k = 1; k <= 4; k++) begin
                pcOut = 1'b1;
                zIn = 1'b1;
                aluOp = datapathPkg::aluInc;
                tick();
                zLowOut = 1'b1;
                pcIn = 1'b1;
                tick();
                pcOut = 1'b1;
                observe("pc increment", 32'(k), 1'b0);
            end

            a = nextRandom();
            b = nextRandom();
            aluSequence(datapathPkg::aluMul, a, b);
            product = aluRef(datapathPkg::aluMul, a, b);
            zHighOut = 1'b1;
            hiIn = 1'b1;
            tick();
            zLowOut = 1'b1;
            loIn = 1'b1;
            tick();
            hiOut = 1'b1;
            observe("hi from product", product[63:32], 1'b0);
            loOut = 1'b1;
            observe("lo from product", product[31:0], 1'b0);

            value = nextRandom();
            inPort = value;
            inPortOut = 1'b1;
            marIn = 1'b1;
            tick();
            if (marAddr !== value) begin
                errorCount++;
                $display("FAILED mar load: expected %h, actual %h", value, marAddr);
            end

            // Two sources at once where the higher one wins
            value = nextRandom();
            mDataIn = value;
            read = 1'b1;
            mdrIn = 1'b1;
            tick();
            mdrOut = 1'b1;
            pcOut = 1'b1;
            observe("mdr over pc", value, 1'b1);
            inPort = a;
            inPortOut = 1'b1;
            cOut = 1'b1;
            observe("inport over immediate", a, 1'b1);
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checkCount, errorCount, dut0.chk0.failCount);
        if (errorCount == 0 && dut0.chk0.failCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/datapath_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module datapathChk (
    input logic                   Clock,
    input logic                   rstN,
    input logic                   rOut,
    input logic                   hiOut,
    input logic                   loOut,
    input logic                   pcOut,
    input logic                   zHighOut,
    input logic                   zLowOut,
    input logic                   mdrOut,
    input logic                   inPortOut,
    input logic                   cOut,
    input logic                   baOut,
    input logic [`DATA_WIDTH-1:0] busData,
    input logic                   busConflict
);

    int   failCount = 0;
    logic noStrobe;
    logic pcOnly;

    assign noStrobe = !(rOut | hiOut | loOut | pcOut | zHighOut | zLowOut |
                        mdrOut | inPortOut | cOut | baOut);
    assign pcOnly   = pcOut && !(rOut | hiOut | loOut | zHighOut | zLowOut |
                                 mdrOut | inPortOut | cOut | baOut);

    // Idle bus never flags a conflict
    assert property (@(posedge Clock) disable iff (!rstN) noStrobe |-> !busConflict)
        else begin
            failCount++;
            $error("busConflict high with no out strobe");
        end

    assert property (@(posedge Clock) disable iff (!rstN) noStrobe |-> busData == '0)
        else begin
            failCount++;
            $error("busData not zero with no out strobe");
        end

    // First cycle out of reset
    assert property (@(posedge Clock) (rstN && !$past(rstN) && pcOnly) |-> busData == '0)
        else begin
            failCount++;
            $error("PC not zero right after reset");
        end

endmodule

bind datapath datapathChk chk0 (
    .Clock, .rstN,
    .rOut, .hiOut, .loOut, .pcOut, .zHighOut, .zLowOut,
    .mdrOut, .inPortOut, .cOut, .baOut,
    .busData, .busConflict
);

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

// 4 ns clock and a reset held low for the first three rising edges
module clockGen (
    output logic Clock,
    output logic rstN
);

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(negedge Clock);
        rstN <= 1'b1;   // Released on a falling edge
    end

endmodule

`default_nettype wire

/* hw/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module datapath (
    input  logic                   Clock,
    input  logic                   rstN,
    // Out strobes, one source at a time
    input  logic                   rOut,
    input  logic                   hiOut,
    input  logic                   loOut,
    input  logic                   pcOut,
    input  logic                   zHighOut,
    input  logic                   zLowOut,
    input  logic                   mdrOut,
    input  logic                   inPortOut,
    input  logic                   cOut,
    input  logic                   baOut,
    // In strobes, load at the next edge
    input  logic                   rIn,
    input  logic                   hiIn,
    input  logic                   loIn,
    input  logic                   pcIn,
    input  logic                   irIn,
    input  logic                   yIn,
    input  logic                   zIn,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   gra,
    input  logic                   grb,
    input  logic                   grc,
    input  logic                   read,
    input  datapathPkg::aluOpT     aluOp,
    input  logic [`DATA_WIDTH-1:0] mDataIn,
    input  logic [`DATA_WIDTH-1:0] inPort,
    output logic [`DATA_WIDTH-1:0] busData,
    output logic [`DATA_WIDTH-1:0] marAddr,
    output logic                   busConflict
);

    busIf bus0 ();

    busDecode decode0 (
        .Clock, .rstN,
        .rOut, .hiOut, .loOut, .pcOut, .zHighOut, .zLowOut,
        .mdrOut, .inPortOut, .cOut, .baOut,
        .gra, .grb, .grc,
        .irIn, .marIn, .mdrIn, .read,
        .mDataIn, .inPort,
        .bus         (bus0.decodeMp),
        .marAddr,
        .busConflict
    );

    aluExecute execute0 (
        .Clock, .rstN,
        .yIn, .zIn,
        .aluOp,
        .bus   (bus0.executeMp)
    );

    registerFile result0 (
        .Clock, .rstN,
        .rIn, .hiIn, .loIn, .pcIn,
        .bus   (bus0.resultMp)
    );

    assign busData = bus0.busData;   // Bus is visible to the testbench

endmodule

`default_nettype wire

/* hw/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module registerFile (
    input  logic Clock,
    input  logic rstN,
    input  logic rIn,
    input  logic hiIn,
    input  logic loIn,
    input  logic pcIn,
    busIf.resultMp bus
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] hiReg;
    logic [`DATA_WIDTH-1:0] loReg;
    logic [`DATA_WIDTH-1:0] pcReg;

    // General registers, written at the IR-selected index
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (rIn) begin
            regs[bus.selReg] <= bus.busData;
        end
    end

    // Special registers
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            hiReg <= '0;
            loReg <= '0;
            pcReg <= '0;
        end else begin
            if (hiIn)
                hiReg <= bus.busData;
            if (loIn)
                loReg <= bus.busData;
            if (pcIn)
                pcReg <= bus.busData;   // PC only changes through the bus
        end
    end

    // Sources offered to the bus mux
    assign bus.rfData = regs[bus.selReg];
    assign bus.hiData = hiReg;
    assign bus.loData = loReg;
    assign bus.pcData = pcReg;

endmodule

`default_nettype wire

/* hw/aluExecute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module aluExecute (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               yIn,
    input  logic               zIn,
    input  datapathPkg::aluOpT aluOp,
    busIf.executeMp            bus
);

    logic [`DATA_WIDTH-1:0]        yReg;
    logic [`Z_WIDTH-1:0]           zReg;
    logic [`DATA_WIDTH-1:0]        opB;        // Bus operand
    logic [4:0]                    shiftAmt;
    logic [`Z_WIDTH-1:0]           yDouble;
    logic [`Z_WIDTH-1:0]           rorWide;
    logic [`Z_WIDTH-1:0]           rolWide;
    logic signed [`Z_WIDTH-1:0]    product;
    logic signed [`DATA_WIDTH-1:0] quotient;
    logic signed [`DATA_WIDTH-1:0] remainder;
    logic [`DATA_WIDTH-1:0]        lowResult;
    logic [`Z_WIDTH-1:0]           aluResult;

    assign opB      = bus.busData;
    assign shiftAmt = opB[4:0];

    // Rotates come out of a doubled copy of Y
    assign yDouble = {yReg, yReg};
    assign rorWide = yDouble >> shiftAmt;
    assign rolWide = yDouble << shiftAmt;

    assign product = $signed(yReg) * $signed(opB);   // Full signed 64-bit product

    always_comb begin
        if (opB == '0) begin
            quotient  = '1;
            remainder = $signed(yReg);   // Divide by zero
        end else begin
            quotient  = $signed(yReg) / $signed(opB);
            remainder = $signed(yReg) % $signed(opB);
        end
    end

    // Single-word results
    always_comb begin
        case (aluOp)
            datapathPkg::aluAdd:  lowResult = yReg + opB;
            datapathPkg::aluSub:  lowResult = yReg - opB;
            datapathPkg::aluAnd:  lowResult = yReg & opB;
            datapathPkg::aluOr:   lowResult = yReg | opB;
            datapathPkg::aluShr:  lowResult = yReg >> shiftAmt;
            datapathPkg::aluShra: lowResult = $signed(yReg) >>> shiftAmt;
            datapathPkg::aluShl:  lowResult = yReg << shiftAmt;
            datapathPkg::aluRor:  lowResult = rorWide[`DATA_WIDTH-1:0];
            datapathPkg::aluRol:  lowResult = rolWide[`Z_WIDTH-1:`DATA_WIDTH];
            datapathPkg::aluNeg:  lowResult = -opB;
            datapathPkg::aluNot:  lowResult = ~opB;
            datapathPkg::aluInc:  lowResult = opB + 1'b1;
            default:              lowResult = '0;
        endcase
    end

    // Multiply and divide fill both halves
    always_comb begin
        case (aluOp)
            datapathPkg::aluMul: aluResult = product;
            datapathPkg::aluDiv: aluResult = {remainder, quotient};
            default:             aluResult = {{`DATA_WIDTH{1'b0}}, lowResult};
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (yIn)
                yReg <= opB;
            if (zIn)
                zReg <= aluResult;
        end
    end

    assign bus.zData = zReg;

endmodule

`default_nettype wire

/* hw/busDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

module busDecode (
    input  logic                   Clock,
    input  logic                   rstN,
    // Out strobes
    input  logic                   rOut,
    input  logic                   hiOut,
    input  logic                   loOut,
    input  logic                   pcOut,
    input  logic                   zHighOut,
    input  logic                   zLowOut,
    input  logic                   mdrOut,
    input  logic                   inPortOut,
    input  logic                   cOut,
    input  logic                   baOut,
    // Register field select
    input  logic                   gra,
    input  logic                   grb,
    input  logic                   grc,
    // In strobes owned by this stage
    input  logic                   irIn,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   read,
    input  logic [`DATA_WIDTH-1:0] mDataIn,
    input  logic [`DATA_WIDTH-1:0] inPort,
    busIf.decodeMp                 bus,
    output logic [`DATA_WIDTH-1:0] marAddr,
    output logic                   busConflict
);

    datapathPkg::instrWordT    irReg;
    logic [`DATA_WIDTH-1:0]    mdrReg;
    logic [`DATA_WIDTH-1:0]    marReg;
    logic [`DATA_WIDTH-1:0]    regSource;
    logic [`DATA_WIDTH-1:0]    immValue;
    logic [`DATA_WIDTH-1:0]    busValue;
    logic [`REG_SEL_WIDTH-1:0] regIndex;
    logic                      regOut;
    logic [8:0]                outStrobes;

    // IR, MDR and MAR
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            irReg  <= '0;
            mdrReg <= '0;
            marReg <= '0;
        end else begin
            if (irIn)
                irReg <= bus.busData;
            if (mdrIn)
                mdrReg <= read ? mDataIn : bus.busData;   // Memory read or bus write-back
            if (marIn)
                marReg <= bus.busData;
        end
    end

    // Register field chosen by the control word
    always_comb begin
        if (gra)
            regIndex = irReg.regFmt.ra;
        else if (grb)
            regIndex = irReg.regFmt.rb;
        else if (grc)
            regIndex = irReg.regFmt.rc;
        else
            regIndex = '0;
    end

    assign regOut    = rOut | baOut;
    assign regSource = (baOut && regIndex == '0) ? '0 : bus.rfData;   // R0 as base reads zero

    // Sign-extended constant from the immediate format
    assign immValue = {{(`DATA_WIDTH - `IMM_WIDTH){irReg.immFmt.imm[`IMM_WIDTH-1]}},
                       irReg.immFmt.imm};

    // Highest priority first
    always_comb begin
        busValue = '0;
        if (mdrOut)
            busValue = mdrReg;
        else if (zLowOut)
            busValue = bus.zData[`DATA_WIDTH-1:0];
        else if (zHighOut)
            busValue = bus.zData[`Z_WIDTH-1:`DATA_WIDTH];
        else if (regOut)
            busValue = regSource;
        else if (hiOut)
            busValue = bus.hiData;
        else if (loOut)
            busValue = bus.loData;
        else if (pcOut)
            busValue = bus.pcData;
        else if (inPortOut)
            busValue = inPort;
        else if (cOut)
            busValue = immValue;
    end

    assign outStrobes = {mdrOut, zLowOut, zHighOut, regOut, hiOut,
                         loOut, pcOut, inPortOut, cOut};

    // More than one bit set when clearing the lowest one leaves something
    assign busConflict = (outStrobes & (outStrobes - 9'd1)) != '0;

    assign bus.busData = busValue;
    assign bus.selReg  = regIndex;
    assign marAddr     = marReg;

endmodule

`default_nettype wire

/* hw/busIf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "datapath_defines.svh"

// Shared bus plus all the values that can be put on it
interface busIf;

    logic [`DATA_WIDTH-1:0]    busData;
    logic [`DATA_WIDTH-1:0]    rfData;   // Selected general register
    logic [`DATA_WIDTH-1:0]    hiData;
    logic [`DATA_WIDTH-1:0]    loData;
    logic [`DATA_WIDTH-1:0]    pcData;
    logic [`Z_WIDTH-1:0]       zData;
    logic [`REG_SEL_WIDTH-1:0] selReg;   // Register index decoded from IR

    // Bus owner, sees every source
    modport decodeMp (
        input  rfData, hiData, loData, pcData, zData,
        output busData, selReg
    );

    modport executeMp (
        input  busData,
        output zData
    );

    modport resultMp (
        input  busData, selReg,
        output rfData, hiData, loData, pcData
    );

endinterface

`default_nettype wire

/* hw/datapathPkg.sv */
`default_nettype none

`include "datapath_defines.svh"

package datapathPkg;

    // ALU operations selected by the control word
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluShr  = 4'd4,
        aluShra = 4'd5,
        aluShl  = 4'd6,
        aluRor  = 4'd7,
        aluRol  = 4'd8,
        aluNeg  = 4'd9,
        aluNot  = 4'd10,
        aluInc  = 4'd11,
        aluMul  = 4'd12,
        aluDiv  = 4'd13
    } aluOpT;

    // Three-register format: op ra, rb, rc
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]    opcode;
        logic [`REG_SEL_WIDTH-1:0]   ra;
        logic [`REG_SEL_WIDTH-1:0]   rb;
        logic [`REG_SEL_WIDTH-1:0]   rc;
        logic [`REG_SPARE_WIDTH-1:0] spare;
    } regFormatT;

    // Immediate format: op ra, rb, constant
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]  opcode;
        logic [`REG_SEL_WIDTH-1:0] ra;
        logic [`REG_SEL_WIDTH-1:0] rb;
        logic [`IMM_WIDTH-1:0]     imm;
    } immFormatT;

    // IR contents seen through either format
    typedef union packed {
        regFormatT regFmt;
        immFormatT immFmt;
    } instrWordT;

endpackage

`default_nettype wire

/* include/datapath_defines.svh */
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// Word width of the shared bus and of every datapath register
`define DATA_WIDTH 32

// General register file size
`define REG_COUNT 16

// Register select field of IR
`define REG_SEL_WIDTH 4

// Instruction field widths
`define OPCODE_WIDTH 5
`define IMM_WIDTH 19

// Spare bits at the bottom of the three-register format
`define REG_SPARE_WIDTH (`DATA_WIDTH - `OPCODE_WIDTH - 3 * `REG_SEL_WIDTH)

// Z holds a double word for multiply and divide
`define Z_WIDTH (2 * `DATA_WIDTH)

`endif
